//--- include/spi_packet_link_params.svh
`ifndef SPI_PACKET_LINK_PARAMS_SVH
`define SPI_PACKET_LINK_PARAMS_SVH

// clk cycles per half sclk period, 1 or more
`define SPI_CLK_DIV 2

// Meta byte + 8 prefix bytes + 32 payload bytes
`define PACKET_BYTES 41

`endif

//--- logic/spi_packet_pkg.sv
package spi_packet_pkg;

    // One byte on the wire
    typedef logic [7:0] spi_byte_t;

    // Packet fields, meta goes out first
    typedef logic [7:0]   meta_t;
    typedef logic [63:0]  prefix_t;
    typedef logic [255:0] payload_t;

    // Byte position within a packet, bit position within a byte
    typedef logic [5:0] byte_idx_t;
    typedef logic [2:0] bit_idx_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_SELECT,
        ENG_LOW,
        ENG_HIGH,
        ENG_RELEASE
    } engine_state_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_LOAD,
        SER_WAIT,
        SER_FINISH
    } ser_state_t;

endpackage

//--- logic/spi_byte_if.sv
`timescale 1ns/1ps

// Byte handoff between the packet blocks and the SPI byte engine
interface spi_byte_if;

    logic                      frame;
    logic                      tx_valid;
    spi_packet_pkg::spi_byte_t tx_byte;
    logic                      ready;
    logic                      rx_valid;
    spi_packet_pkg::spi_byte_t rx_byte;

    // Packet source, owns the frame
    modport master (
        output frame,
        output tx_valid,
        output tx_byte,
        input  ready,
        input  rx_valid
    );

    modport engine (
        input  frame,
        input  tx_valid,
        input  tx_byte,
        output ready,
        output rx_valid,
        output rx_byte
    );

    // Receive side only listens
    modport monitor (
        input frame,
        input rx_valid,
        input rx_byte
    );

endinterface

//--- logic/spi_byte_engine.sv
`timescale 1ns/1ps

`include "spi_packet_link_params.svh"

// SPI mode 0 master, one full duplex byte per tx_valid
module spi_byte_engine (
    input  logic       clk,
    input  logic       arst_n,
    spi_byte_if.engine bus,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso,
    output logic       cs_n
);

    // One spare bit so a divider of 1 still gives a legal width
    localparam int unsigned HALF_W = $clog2(`SPI_CLK_DIV) + 1;
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`SPI_CLK_DIV - 1);

    spi_packet_pkg::engine_state_t state;
    logic [HALF_W-1:0]             half_cnt;
    logic                          half_done;
    logic                          sclk_rise;
    spi_packet_pkg::bit_idx_t      bit_idx;
    spi_packet_pkg::spi_byte_t     tx_shift;
    spi_packet_pkg::spi_byte_t     rx_shift;

    assign half_done = (half_cnt == HALF_LAST);

    // Rising edge comes out of both the chip select wait and the low phase
    assign sclk_rise = half_done &&
                       (state == spi_packet_pkg::ENG_SELECT ||
                        state == spi_packet_pkg::ENG_LOW);

    // MSB of the shifter is the line, so it moves on each falling edge
    assign mosi = tx_shift[7];

    // Last sample lands on the 8th rise, well before the next byte starts
    assign bus.rx_byte = rx_shift;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= spi_packet_pkg::ENG_IDLE;
            half_cnt     <= '0;
            bit_idx      <= '0;
            tx_shift     <= '0;
            sclk         <= 1'b0;
            cs_n         <= 1'b1;
            bus.ready    <= 1'b1;
            bus.rx_valid <= 1'b0;
        end else begin
            bus.rx_valid <= 1'b0;

            if (state == spi_packet_pkg::ENG_IDLE || half_done) begin
                half_cnt <= '0;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end

            case (state)
                spi_packet_pkg::ENG_IDLE: begin
                    if (bus.tx_valid) begin
                        tx_shift  <= bus.tx_byte;
                        bit_idx   <= '0;
                        bus.ready <= 1'b0;
                        cs_n      <= 1'b0;
                        // Mid-frame bytes skip the chip select setup
                        if (cs_n) begin
                            state <= spi_packet_pkg::ENG_SELECT;
                        end else begin
                            state <= spi_packet_pkg::ENG_LOW;
                        end
                    end else if (!bus.frame && !cs_n) begin
                        // Not ready again until cs_n is back up
                        bus.ready <= 1'b0;
                        state     <= spi_packet_pkg::ENG_RELEASE;
                    end
                end

                spi_packet_pkg::ENG_SELECT,
                spi_packet_pkg::ENG_LOW: begin
                    if (half_done) begin
                        sclk  <= 1'b1;
                        state <= spi_packet_pkg::ENG_HIGH;
                    end
                end

                spi_packet_pkg::ENG_HIGH: begin
                    if (half_done) begin
                        sclk     <= 1'b0;
                        tx_shift <= tx_shift << 1;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            bus.rx_valid <= 1'b1;
                            bus.ready    <= 1'b1;
                            state        <= spi_packet_pkg::ENG_IDLE;
                        end else begin
                            state <= spi_packet_pkg::ENG_LOW;
                        end
                    end
                end

                spi_packet_pkg::ENG_RELEASE: begin
                    // Hold time after the last falling edge
                    if (half_done) begin
                        cs_n      <= 1'b1;
                        bus.ready <= 1'b1;
                        state     <= spi_packet_pkg::ENG_IDLE;
                    end
                end

                default: begin
                    state <= spi_packet_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    // Sample miso on the rising edge
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], miso};
        end
    end

endmodule

//--- logic/packet_serializer.sv
`timescale 1ns/1ps

`include "spi_packet_link_params.svh"

// Splits one packet into bytes for the engine and keeps the frame open
module packet_serializer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  spi_packet_pkg::meta_t    tx_meta,
    input  spi_packet_pkg::prefix_t  tx_prefix,
    input  spi_packet_pkg::payload_t tx_payload,
    output logic                     busy,
    spi_byte_if.master               bus
);

    localparam int unsigned PKT_W = `PACKET_BYTES * 8;
    localparam spi_packet_pkg::byte_idx_t LAST_IDX =
        spi_packet_pkg::byte_idx_t'(`PACKET_BYTES - 1);

    spi_packet_pkg::ser_state_t state;
    spi_packet_pkg::byte_idx_t  rx_count;
    logic [PKT_W-1:0]           pkt_shift;
    logic                       accept;
    logic                       last_rx;
    logic                       issue;

    assign accept  = (state == spi_packet_pkg::SER_IDLE) && start;
    assign last_rx = bus.rx_valid && (rx_count == LAST_IDX);

    // Next byte goes out in the cycle after ready comes back
    assign issue = (state == spi_packet_pkg::SER_LOAD) && bus.ready && !last_rx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= spi_packet_pkg::SER_IDLE;
            rx_count     <= '0;
            busy         <= 1'b0;
            bus.frame    <= 1'b0;
            bus.tx_valid <= 1'b0;
        end else begin
            case (state)
                spi_packet_pkg::SER_IDLE: begin
                    if (accept) begin
                        busy      <= 1'b1;
                        bus.frame <= 1'b1;
                        rx_count  <= '0;
                        state     <= spi_packet_pkg::SER_LOAD;
                    end
                end

                spi_packet_pkg::SER_LOAD: begin
                    if (bus.rx_valid) begin
                        rx_count <= rx_count + 1'b1;
                    end
                    if (last_rx) begin
                        bus.frame <= 1'b0;
                        state     <= spi_packet_pkg::SER_WAIT;
                    end else if (issue) begin
                        bus.tx_valid <= 1'b1;
                        state        <= spi_packet_pkg::SER_WAIT;
                    end
                end

                // One cycle for ready to drop, or for the engine to see frame low
                spi_packet_pkg::SER_WAIT: begin
                    bus.tx_valid <= 1'b0;
                    if (bus.frame) begin
                        state <= spi_packet_pkg::SER_LOAD;
                    end else begin
                        state <= spi_packet_pkg::SER_FINISH;
                    end
                end

                spi_packet_pkg::SER_FINISH: begin
                    // Engine raises ready again only once cs_n is high
                    if (bus.ready) begin
                        busy  <= 1'b0;
                        state <= spi_packet_pkg::SER_IDLE;
                    end
                end

                default: begin
                    state <= spi_packet_pkg::SER_IDLE;
                end
            endcase
        end
    end

    // Packet shifter, top byte is always the next to send
    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_shift <= {tx_meta, tx_prefix, tx_payload};
        end else if (issue) begin
            bus.tx_byte <= pkt_shift[PKT_W-1 -: 8];
            pkt_shift   <= pkt_shift << 8;
        end
    end

endmodule

//--- logic/packet_collector.sv
`timescale 1ns/1ps

`include "spi_packet_link_params.svh"

// Rebuilds meta, prefix and payload from the received byte stream
module packet_collector (
    input  logic                      clk,
    input  logic                      arst_n,
    spi_byte_if.monitor               bus,
    output logic                      rx_valid,
    output spi_packet_pkg::meta_t     rx_meta,
    output spi_packet_pkg::prefix_t   rx_prefix,
    output spi_packet_pkg::payload_t  rx_payload
);

    // Shifter holds every byte but the last, which comes straight off the bus
    localparam int unsigned HOLD_W = (`PACKET_BYTES - 1) * 8;
    localparam spi_packet_pkg::byte_idx_t LAST_IDX =
        spi_packet_pkg::byte_idx_t'(`PACKET_BYTES - 1);

    spi_packet_pkg::byte_idx_t byte_count;
    logic [HOLD_W-1:0]         pkt_shift;
    logic                      last_byte;

    assign last_byte = bus.rx_valid && (byte_count == LAST_IDX);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_count <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= last_byte;
            // Count restarts between frames
            if (!bus.frame) begin
                byte_count <= '0;
            end else if (bus.rx_valid) begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rx_valid) begin
            pkt_shift <= {pkt_shift[HOLD_W-9:0], bus.rx_byte};
        end
        // Fields only move when a whole packet is in
        if (last_byte) begin
            {rx_meta, rx_prefix, rx_payload} <= {pkt_shift, bus.rx_byte};
        end
    end

endmodule

//--- logic/spi_packet_link.sv
`timescale 1ns/1ps

// Packet level SPI master, transmit and receive share one byte engine
module spi_packet_link (
    input  logic                     clk,
    input  logic                     arst_n,

    // Host side
    input  logic                     start,
    input  spi_packet_pkg::meta_t    tx_meta,
    input  spi_packet_pkg::prefix_t  tx_prefix,
    input  spi_packet_pkg::payload_t tx_payload,
    output logic                     busy,
    output logic                     rx_valid,
    output spi_packet_pkg::meta_t    rx_meta,
    output spi_packet_pkg::prefix_t  rx_prefix,
    output spi_packet_pkg::payload_t rx_payload,

    // SPI pins
    output logic                     sclk,
    output logic                     mosi,
    input  logic                     miso,
    output logic                     cs_n
);

    spi_byte_if i_byte_if ();

    packet_serializer i_packet_serializer (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .tx_meta    (tx_meta),
        .tx_prefix  (tx_prefix),
        .tx_payload (tx_payload),
        .busy       (busy),
        .bus        (i_byte_if.master)
    );

    spi_byte_engine i_spi_byte_engine (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (i_byte_if.engine),
        .sclk   (sclk),
        .mosi   (mosi),
        .miso   (miso),
        .cs_n   (cs_n)
    );

    // Listens on the same byte stream the serializer drives
    packet_collector i_packet_collector (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus        (i_byte_if.monitor),
        .rx_valid   (rx_valid),
        .rx_meta    (rx_meta),
        .rx_prefix  (rx_prefix),
        .rx_payload (rx_payload)
    );

endmodule

//--- verif/spi_packet_link_checker.sv
`timescale 1ns/1ps

// Pin level rules for the packet link
module spi_packet_link_checker (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic rx_valid,
    input logic sclk,
    input logic cs_n
);

    int unsigned fail_count = 0;
    logic        rx_seen;

    // Set by the packet received since busy rose
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_seen <= 1'b0;
        end else if (!busy) begin
            rx_seen <= 1'b0;
        end else if (rx_valid) begin
            rx_seen <= 1'b1;
        end
    end

    idle_pins: assert property (@(posedge clk) disable iff (!arst_n)
        !busy |-> (cs_n && !sclk))
        else begin
            fail_count++;
            $error("cs_n low or sclk high while busy is low");
        end

    // No clock edges outside a selected frame
    quiet_sclk: assert property (@(posedge clk) disable iff (!arst_n)
        cs_n |-> $stable(sclk))
        else begin
            fail_count++;
            $error("sclk toggled while cs_n is high");
        end

    single_rx_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid high for more than one cycle");
        end

    busy_after_rx: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> rx_seen)
        else begin
            fail_count++;
            $error("busy fell before any rx_valid");
        end

endmodule

bind spi_packet_link spi_packet_link_checker i_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .busy     (busy),
    .rx_valid (rx_valid),
    .sclk     (sclk),
    .cs_n     (cs_n)
);

//--- verif/spi_packet_link_tb.sv
`timescale 1ns/1ps

`include "spi_packet_link_params.svh"

module spi_packet_link_tb;

    localparam int PKT_W   = `PACKET_BYTES * 8;
    localparam int TIMEOUT = 20000;

    logic                     clk;
    logic                     arst_n;
    logic                     start;
    spi_packet_pkg::meta_t    tx_meta;
    spi_packet_pkg::prefix_t  tx_prefix;
    spi_packet_pkg::payload_t tx_payload;
    logic                     busy;
    logic                     rx_valid;
    spi_packet_pkg::meta_t    rx_meta;
    spi_packet_pkg::prefix_t  rx_prefix;
    spi_packet_pkg::payload_t rx_payload;
    logic                     sclk;
    logic                     mosi;
    logic                     miso;
    logic                     cs_n;

    logic [PKT_W-1:0] tx_pkt, resp_pkt, resp_shift, mosi_cap, rx_pkt;
    int               sclk_rises, rises_at_release, cs_falls, cs_rises, rx_pulses;
    int               err_count, err_mark, tests_run, tests_failed;
    integer           seed;
    realtime          cs_rise_time, busy_fall_time;

    spi_packet_link i_spi_packet_link (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .tx_meta    (tx_meta),
        .tx_prefix  (tx_prefix),
        .tx_payload (tx_payload),
        .busy       (busy),
        .rx_valid   (rx_valid),
        .rx_meta    (rx_meta),
        .rx_prefix  (rx_prefix),
        .rx_payload (rx_payload),
        .sclk       (sclk),
        .mosi       (mosi),
        .miso       (miso),
        .cs_n       (cs_n)
    );

    always #50 clk = ~clk;

    // Loopback slave drives the response MSB on miso
    assign miso = resp_shift[PKT_W-1];

    always @(negedge cs_n) begin
        resp_shift = resp_pkt;
        cs_falls++;
    end

    always @(negedge sclk) begin
        if (!cs_n) begin
            resp_shift = resp_shift << 1;
        end
    end

    // Master data is stable on the rising edge
    always @(posedge sclk) begin
        if (!cs_n) begin
            mosi_cap = {mosi_cap[PKT_W-2:0], mosi};
            sclk_rises++;
        end
    end

    always @(posedge cs_n) begin
        cs_rises++;
        rises_at_release = sclk_rises;
        cs_rise_time = $realtime;
    end

    always @(negedge busy) begin
        busy_fall_time = $realtime;
    end

    // Reads the fields as they were while rx_valid was high
    always @(posedge clk) begin
        if (rx_valid) begin
            rx_pulses++;
            rx_pkt = {rx_meta, rx_prefix, rx_payload};
        end
    end

    function automatic int total_errors();
        return err_count + int'(i_spi_packet_link.i_checker.fail_count);
    endfunction

    function automatic logic [PKT_W-1:0] random_packet();
        logic [PKT_W-1:0] pkt;
        pkt = '0;
        for (int i = 0; i < (PKT_W + 31) / 32; i++) begin
            pkt = {pkt[PKT_W-33:0], 32'($random(seed))};
        end
        return pkt;
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("FAIL %0d ns: %s", $time, msg);
            err_count++;
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = total_errors() - err_mark;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errs);
            tests_failed++;
        end
        err_mark = total_errors();
    endtask

    task automatic stop_on_timeout(input string what);
        $display("ERROR: no %s within %0d clock cycles, run stopped", what, TIMEOUT);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_busy_low();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_on_timeout("fall of busy");
            end
        end
    endtask

    // One packet from start until busy drops again
    task automatic run_transfer(input logic [PKT_W-1:0] pkt, input logic [PKT_W-1:0] resp,
                                input bit extra_start);
        resp_pkt = resp;
        {tx_meta, tx_prefix, tx_payload} = pkt;
        mosi_cap = '0;
        sclk_rises = 0;
        rises_at_release = -1;
        cs_falls = 0;
        cs_rises = 0;
        rx_pulses = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        expect_true(busy === 1'b1, "busy did not rise after start");
        if (extra_start) begin
            repeat (20) @(negedge clk);
            expect_true(busy === 1'b1, "busy low before the second start");
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_busy_low();
    endtask

    task automatic check_receive(input logic [PKT_W-1:0] resp);
        expect_true(rx_pulses == 1, $sformatf("rx_valid pulsed %0d times", rx_pulses));
        expect_true(rx_pkt === resp, $sformatf("received %h, expected %h", rx_pkt, resp));
    endtask

    initial begin
        seed = 17757;
        clk = 1'b0;
        arst_n = 1'b0;
        start = 1'b0;
        tx_meta = '0;
        tx_prefix = '0;
        tx_payload = '0;
        resp_pkt = '0;
        resp_shift = '0;
        mosi_cap = '0;
        rx_pkt = '0;
        err_count = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        repeat (20) begin
            @(negedge clk);
            expect_true(cs_n === 1'b1 && sclk === 1'b0 && mosi === 1'b0 &&
                        busy === 1'b0 && rx_valid === 1'b0, "pins not idle after reset");
        end
        report_test("reset state");

        tx_pkt = {8'h28, 64'd129, spi_packet_pkg::payload_t'("here is data")};
        resp_pkt = {8'hc3, 64'h0123_4567_89ab_cdef, spi_packet_pkg::payload_t'("slave reply")};
        run_transfer(tx_pkt, resp_pkt, 1'b0);
        expect_true(mosi_cap === tx_pkt, $sformatf("mosi %h, expected %h", mosi_cap, tx_pkt));
        report_test("transmit");
        check_receive(resp_pkt);
        report_test("receive");
        expect_true(cs_falls == 1 && cs_rises == 1,
                    $sformatf("cs_n fell %0d and rose %0d times", cs_falls, cs_rises));
        expect_true(sclk_rises == PKT_W, $sformatf("%0d sclk rises", sclk_rises));
        expect_true(rises_at_release == PKT_W,
                    $sformatf("cs_n rose after %0d sclk rises", rises_at_release));
        expect_true(cs_rise_time < busy_fall_time, "busy fell before cs_n rose");
        report_test("continuous chip select");

        tx_pkt = random_packet();
        resp_pkt = random_packet();
        run_transfer(tx_pkt, resp_pkt, 1'b1);
        expect_true(mosi_cap === tx_pkt, $sformatf("mosi %h, expected %h", mosi_cap, tx_pkt));
        check_receive(resp_pkt);
        expect_true(sclk_rises == PKT_W, $sformatf("%0d sclk rises", sclk_rises));
        repeat (10) begin
            @(negedge clk);
            expect_true(busy === 1'b0 && cs_n === 1'b1 && cs_falls == 1,
                        "second start began another packet");
        end
        report_test("start while busy");

        repeat (8) begin
            tx_pkt = random_packet();
            resp_pkt = random_packet();
            run_transfer(tx_pkt, resp_pkt, 1'b0);
            expect_true(mosi_cap === tx_pkt,
                        $sformatf("mosi %h, expected %h", mosi_cap, tx_pkt));
            check_receive(resp_pkt);
        end
        report_test("random packets");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- spi_packet_link.f
+incdir+include
logic/spi_packet_pkg.sv
logic/spi_byte_if.sv
logic/spi_byte_engine.sv
logic/packet_serializer.sv
logic/packet_collector.sv
logic/spi_packet_link.sv
verif/spi_packet_link_checker.sv
verif/spi_packet_link_tb.sv
